//--- verilog/ext_subsys_pkg.sv
// *************************************************
// Address map, sizes and latencies of the subsystem
// Only addresses below 0x2000 are mapped; bit 12 picks the target
// *************************************************
package ext_subsys_pkg;

  localparam int DATA_WIDTH         = 32;
  localparam int ADDR_WIDTH         = 32;
  localparam int MEM_WORDS          = 128;
  localparam int MEM_IDX_WIDTH      = 7;
  localparam int EXT_DOMAINS        = 4;
  localparam int SWITCH_ACK_LATENCY = 15;
  localparam int SLOW_GNT_DELAY     = 3;

  // Register offsets as carried on the CSR bus
  localparam logic [MEM_IDX_WIDTH-1:0] CSR_SRC_OFFSET    = 7'h00;
  localparam logic [MEM_IDX_WIDTH-1:0] CSR_DST_OFFSET    = 7'h04;
  localparam logic [MEM_IDX_WIDTH-1:0] CSR_SIZE_OFFSET   = 7'h08;
  localparam logic [MEM_IDX_WIDTH-1:0] CSR_STATUS_OFFSET = 7'h0C;

  localparam logic REGION_CSR = 1'b0;
  localparam logic REGION_MEM = 1'b1;

  // Decoder states
  localparam logic [1:0] DEC_IDLE = 2'd0;
  localparam logic [1:0] DEC_REQ  = 2'd1;
  localparam logic [1:0] DEC_RSP  = 2'd2;
  localparam logic [1:0] DEC_DONE = 2'd3;

  // Copy engine states
  localparam logic [2:0] CP_IDLE    = 3'd0;
  localparam logic [2:0] CP_RD_REQ  = 3'd1;
  localparam logic [2:0] CP_RD_WAIT = 3'd2;
  localparam logic [2:0] CP_WR_REQ  = 3'd3;
  localparam logic [2:0] CP_WR_WAIT = 3'd4;

  typedef struct packed {
    logic [18:0] upper;
    logic        region;
    logic [11:0] offset;
  } csr_addr_t;

  typedef struct packed {
    logic [18:0]              upper;
    logic                     region;
    logic [2:0]               pad;
    logic [MEM_IDX_WIDTH-1:0] word_idx;
    logic [1:0]               byte_sel;
  } mem_addr_t;

  typedef union packed {
    csr_addr_t csr;
    mem_addr_t mem;
  } reg_addr_u;

endpackage

//--- verilog/obi_if.sv
// *************************************************
// Word-indexed memory bus; master holds req until gnt
// rvalid follows gnt by one cycle, one transaction at a time
// *************************************************
`timescale 1ns/10ps

interface obi_if ();
  import ext_subsys_pkg::*;

  logic                     req;
  logic                     we;
  logic [MEM_IDX_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0]    wdata;
  logic                     gnt;
  logic                     rvalid;
  logic [DATA_WIDTH-1:0]    rdata;

  modport master (output req, we, addr, wdata, input gnt, rvalid, rdata);
  modport slave (input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

//--- verilog/switch_ack_delay.sv
// *************************************************
// Power-switch cell model, ack trails request by 15 cycles
// *************************************************
`timescale 1ns/10ps

module switch_ack_delay (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic [ext_subsys_pkg::EXT_DOMAINS-1:0] switch_i,
  output logic [ext_subsys_pkg::EXT_DOMAINS-1:0] switch_ack_o
);
  import ext_subsys_pkg::*;

  logic [EXT_DOMAINS-1:0] stage_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= switch_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_o = stage_q[SWITCH_ACK_LATENCY-1];

endmodule

//--- verilog/slow_memory.sv
// *************************************************
// Grant after SLOW_GNT_DELAY cycles of held request
// Contents are undefined until written
// *************************************************
`timescale 1ns/10ps

module slow_memory (
  input logic  clk_i,
  input logic  rst_n_i,
  obi_if.slave mem_bus
);
  import ext_subsys_pkg::*;

  logic [DATA_WIDTH-1:0]               mem_q [MEM_WORDS];
  logic [$clog2(SLOW_GNT_DELAY+1)-1:0] wait_cnt_q;
  logic                                gnt;
  logic                                rvalid_q;
  logic [DATA_WIDTH-1:0]               rdata_q;

  assign gnt = mem_bus.req && (wait_cnt_q == SLOW_GNT_DELAY);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wait_cnt_q <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      if (!mem_bus.req || gnt) begin
        wait_cnt_q <= '0;
      end else begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  // Writes land on the grant cycle
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (mem_bus.we) begin
        mem_q[mem_bus.addr] <= mem_bus.wdata;
      end else begin
        rdata_q <= mem_q[mem_bus.addr];
      end
    end
  end

  assign mem_bus.gnt    = gnt;
  assign mem_bus.rvalid = rvalid_q;
  assign mem_bus.rdata  = rdata_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_bus.rvalid |-> $past(mem_bus.gnt));

endmodule

//--- verilog/obi_arbiter.sv
// *************************************************
// Fixed priority, host first; owner kept until its rvalid
// *************************************************
`timescale 1ns/10ps

module obi_arbiter (
  input  logic  clk_i,
  input  logic  rst_n_i,
  obi_if.slave  host_bus,
  obi_if.slave  copy_bus,
  obi_if.master mem_bus
);

  logic lock_q;
  logic owner_q;
  logic wait_rsp_q;
  logic sel_copy;
  logic sel_req;

  // Owner is frozen from the first presented request
  assign sel_copy = lock_q ? owner_q : !host_bus.req;
  assign sel_req  = sel_copy ? copy_bus.req : host_bus.req;

  assign mem_bus.req   = sel_req && !wait_rsp_q;
  assign mem_bus.we    = sel_copy ? copy_bus.we : host_bus.we;
  assign mem_bus.addr  = sel_copy ? copy_bus.addr : host_bus.addr;
  assign mem_bus.wdata = sel_copy ? copy_bus.wdata : host_bus.wdata;

  assign host_bus.gnt    = mem_bus.gnt && !sel_copy;
  assign copy_bus.gnt    = mem_bus.gnt && sel_copy;
  assign host_bus.rvalid = mem_bus.rvalid && !owner_q;
  assign copy_bus.rvalid = mem_bus.rvalid && owner_q;
  assign host_bus.rdata  = mem_bus.rdata;
  assign copy_bus.rdata  = mem_bus.rdata;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q     <= 1'b0;
      owner_q    <= 1'b0;
      wait_rsp_q <= 1'b0;
    end else begin
      if (!lock_q && sel_req) begin
        lock_q  <= 1'b1;
        owner_q <= sel_copy;
      end
      if (mem_bus.gnt) begin
        wait_rsp_q <= 1'b1;
      end
      if (mem_bus.rvalid) begin
        lock_q     <= 1'b0;
        wait_rsp_q <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(host_bus.gnt && copy_bus.gnt));

  // Response goes back to the granted master only
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    copy_bus.gnt |=> copy_bus.rvalid && !host_bus.rvalid);

endmodule

//--- verilog/memcopy_ctrl.sv
// *************************************************
// SIZE write starts a copy; refused with rdata bit 31 while busy
// Word indices come from byte address bits 8:2 and wrap at 128
// *************************************************
`timescale 1ns/10ps

module memcopy_ctrl (
  input  logic  clk_i,
  input  logic  rst_n_i,
  obi_if.slave  csr_bus,
  obi_if.master copy_bus,
  output logic  intr_o
);
  import ext_subsys_pkg::*;

  logic [DATA_WIDTH-1:0]    src_q;
  logic [DATA_WIDTH-1:0]    dst_q;
  logic [DATA_WIDTH-1:0]    size_q;
  logic [DATA_WIDTH-1:0]    remain_q;
  logic [MEM_IDX_WIDTH-1:0] rd_idx_q;
  logic [MEM_IDX_WIDTH-1:0] wr_idx_q;
  logic [DATA_WIDTH-1:0]    data_q;
  logic [2:0]               state_q;
  logic                     done_q;
  logic                     busy;
  logic                     size_wr;
  logic                     status_rd;
  logic                     csr_rvalid_q;
  logic [DATA_WIDTH-1:0]    csr_rdata_q;

  assign busy      = (state_q != CP_IDLE);
  assign size_wr   = csr_bus.req && csr_bus.we && (csr_bus.addr == CSR_SIZE_OFFSET);
  assign status_rd = csr_bus.req && !csr_bus.we && (csr_bus.addr == CSR_STATUS_OFFSET);

  // Register accesses are accepted at once
  assign csr_bus.gnt    = csr_bus.req;
  assign csr_bus.rvalid = csr_rvalid_q;
  assign csr_bus.rdata  = csr_rdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      csr_rvalid_q <= 1'b0;
    end else begin
      csr_rvalid_q <= csr_bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (csr_bus.req) begin
      if (csr_bus.we) begin
        csr_rdata_q <= {size_wr && busy, {(DATA_WIDTH-1){1'b0}}};
      end else begin
        case (csr_bus.addr)
          CSR_SRC_OFFSET:    csr_rdata_q <= src_q;
          CSR_DST_OFFSET:    csr_rdata_q <= dst_q;
          CSR_SIZE_OFFSET:   csr_rdata_q <= size_q;
          CSR_STATUS_OFFSET: csr_rdata_q <= {{(DATA_WIDTH-2){1'b0}}, busy, done_q};
          default:           csr_rdata_q <= '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q    <= '0;
      dst_q    <= '0;
      size_q   <= '0;
      remain_q <= '0;
      rd_idx_q <= '0;
      wr_idx_q <= '0;
      state_q  <= CP_IDLE;
      done_q   <= 1'b0;
    end else begin
      if (csr_bus.req && csr_bus.we && (csr_bus.addr == CSR_SRC_OFFSET)) begin
        src_q <= csr_bus.wdata;
      end
      if (csr_bus.req && csr_bus.we && (csr_bus.addr == CSR_DST_OFFSET)) begin
        dst_q <= csr_bus.wdata;
      end
      if (status_rd) begin
        done_q <= 1'b0;
      end
      case (state_q)
        CP_IDLE: begin
          if (size_wr) begin
            size_q   <= csr_bus.wdata;
            remain_q <= csr_bus.wdata;
            rd_idx_q <= src_q[MEM_IDX_WIDTH+1:2];
            wr_idx_q <= dst_q[MEM_IDX_WIDTH+1:2];
            done_q   <= (csr_bus.wdata == '0);
            if (csr_bus.wdata != '0) begin
              state_q <= CP_RD_REQ;
            end
          end
        end
        CP_RD_REQ: begin
          if (copy_bus.gnt) begin
            state_q <= CP_RD_WAIT;
          end
        end
        CP_RD_WAIT: begin
          if (copy_bus.rvalid) begin
            state_q <= CP_WR_REQ;
          end
        end
        CP_WR_REQ: begin
          if (copy_bus.gnt) begin
            state_q <= CP_WR_WAIT;
          end
        end
        CP_WR_WAIT: begin
          if (copy_bus.rvalid) begin
            rd_idx_q <= rd_idx_q + 1'b1;
            wr_idx_q <= wr_idx_q + 1'b1;
            remain_q <= remain_q - 1'b1;
            if (remain_q == 1) begin
              state_q <= CP_IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= CP_RD_REQ;
            end
          end
        end
        default: begin
          state_q <= CP_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == CP_RD_WAIT) && copy_bus.rvalid) begin
      data_q <= copy_bus.rdata;
    end
  end

  assign copy_bus.req   = (state_q == CP_RD_REQ) || (state_q == CP_WR_REQ);
  assign copy_bus.we    = (state_q == CP_WR_REQ);
  assign copy_bus.addr  = (state_q == CP_WR_REQ) ? wr_idx_q : rd_idx_q;
  assign copy_bus.wdata = data_q;
  assign intr_o         = done_q;

  // No memory traffic to or from the engine while idle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !busy |-> !copy_bus.req && !copy_bus.rvalid);

endmodule

//--- verilog/periph_decoder.sv
// *************************************************
// Unmapped addresses get an error answer after one cycle
// CSR writes report a refused command through rdata bit 31
// *************************************************
`timescale 1ns/10ps

module periph_decoder (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  reg_valid_i,
  input  logic                                  reg_write_i,
  input  logic [ext_subsys_pkg::ADDR_WIDTH-1:0] reg_addr_i,
  input  logic [ext_subsys_pkg::DATA_WIDTH-1:0] reg_wdata_i,
  output logic                                  reg_ready_o,
  output logic [ext_subsys_pkg::DATA_WIDTH-1:0] reg_rdata_o,
  output logic                                  reg_error_o,
  obi_if.master                                 csr_bus,
  obi_if.master                                 mem_bus
);
  import ext_subsys_pkg::*;

  reg_addr_u             addr_u;
  logic                  addr_ok;
  logic                  hit_csr;
  logic                  hit_mem;
  logic                  tgt_mem;
  logic                  tgt_gnt;
  logic                  tgt_rvalid;
  logic [DATA_WIDTH-1:0] tgt_rdata;
  logic [1:0]            state_q;
  logic                  target_mem_q;
  logic                  error_q;
  logic [DATA_WIDTH-1:0] rdata_q;

  assign addr_u  = reg_addr_i;
  assign addr_ok = (addr_u.csr.upper == '0);
  assign hit_csr = addr_ok && (addr_u.csr.region == REGION_CSR);
  assign hit_mem = addr_ok && (addr_u.mem.region == REGION_MEM);

  assign csr_bus.req   = ((state_q == DEC_IDLE) && reg_valid_i && hit_csr) ||
                         ((state_q == DEC_REQ) && !target_mem_q);
  assign csr_bus.we    = reg_write_i;
  assign csr_bus.addr  = addr_u.csr.offset[MEM_IDX_WIDTH-1:0];
  assign csr_bus.wdata = reg_wdata_i;

  assign mem_bus.req   = ((state_q == DEC_IDLE) && reg_valid_i && hit_mem) ||
                         ((state_q == DEC_REQ) && target_mem_q);
  assign mem_bus.we    = reg_write_i;
  assign mem_bus.addr  = addr_u.mem.word_idx;
  assign mem_bus.wdata = reg_wdata_i;

  // Target is still open while idle, latched afterwards
  assign tgt_mem    = (state_q == DEC_IDLE) ? hit_mem : target_mem_q;
  assign tgt_gnt    = tgt_mem ? mem_bus.gnt : csr_bus.gnt;
  assign tgt_rvalid = target_mem_q ? mem_bus.rvalid : csr_bus.rvalid;
  assign tgt_rdata  = target_mem_q ? mem_bus.rdata : csr_bus.rdata;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= DEC_IDLE;
      target_mem_q <= 1'b0;
      error_q      <= 1'b0;
    end else begin
      case (state_q)
        DEC_IDLE: begin
          if (reg_valid_i) begin
            target_mem_q <= hit_mem;
            error_q      <= !addr_ok;
            if (!addr_ok) begin
              state_q <= DEC_DONE;
            end else if (tgt_gnt) begin
              state_q <= DEC_RSP;
            end else begin
              state_q <= DEC_REQ;
            end
          end
        end
        DEC_REQ: begin
          if (tgt_gnt) begin
            state_q <= DEC_RSP;
          end
        end
        DEC_RSP: begin
          if (tgt_rvalid) begin
            error_q <= !target_mem_q && reg_write_i && tgt_rdata[DATA_WIDTH-1];
            state_q <= DEC_DONE;
          end
        end
        default: begin
          // Host drops its request in this cycle
          state_q <= DEC_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == DEC_IDLE) && reg_valid_i && !addr_ok) begin
      rdata_q <= '0;
    end else if ((state_q == DEC_RSP) && tgt_rvalid) begin
      rdata_q <= tgt_rdata;
    end
  end

  assign reg_ready_o = (state_q == DEC_DONE);
  assign reg_rdata_o = rdata_q;
  assign reg_error_o = error_q;

  // Never both targets at once
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(csr_bus.req && mem_bus.req));

endmodule

//--- verilog/ext_subsystem.sv
// *************************************************
// External subsystem with copy engine, slow memory and switch acks
// Host holds its request until reg_ready_o pulses
// *************************************************
`timescale 1ns/10ps

module ext_subsystem (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   reg_valid_i,
  input  logic                                   reg_write_i,
  input  logic [ext_subsys_pkg::ADDR_WIDTH-1:0]  reg_addr_i,
  input  logic [ext_subsys_pkg::DATA_WIDTH-1:0]  reg_wdata_i,
  output logic                                   reg_ready_o,
  output logic [ext_subsys_pkg::DATA_WIDTH-1:0]  reg_rdata_o,
  output logic                                   reg_error_o,
  output logic                                   intr_o,
  input  logic [ext_subsys_pkg::EXT_DOMAINS-1:0] powergate_switch_i,
  output logic [ext_subsys_pkg::EXT_DOMAINS-1:0] powergate_switch_ack_o
);

  obi_if csr_bus ();
  obi_if host_mem_bus ();
  obi_if copy_bus ();
  obi_if mem_bus ();

  periph_decoder periph_decoder_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .reg_valid_i(reg_valid_i),
    .reg_write_i(reg_write_i),
    .reg_addr_i (reg_addr_i),
    .reg_wdata_i(reg_wdata_i),
    .reg_ready_o(reg_ready_o),
    .reg_rdata_o(reg_rdata_o),
    .reg_error_o(reg_error_o),
    .csr_bus    (csr_bus),
    .mem_bus    (host_mem_bus)
  );

  memcopy_ctrl memcopy_ctrl_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .csr_bus (csr_bus),
    .copy_bus(copy_bus),
    .intr_o  (intr_o)
  );

  obi_arbiter obi_arbiter_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .host_bus(host_mem_bus),
    .copy_bus(copy_bus),
    .mem_bus (mem_bus)
  );

  slow_memory slow_ram_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .mem_bus(mem_bus)
  );

  switch_ack_delay switch_ack_delay_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .switch_i    (powergate_switch_i),
    .switch_ack_o(powergate_switch_ack_o)
  );

endmodule

//--- tests/tb_ext_subsystem.sv
// *************************************************
// Memory contents are only compared where written first
// Copies in these tests use non-overlapping ranges
// *************************************************
`timescale 1ns/10ps

module tb_ext_subsystem;
  import ext_subsys_pkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = 20 * NUM_TESTS * MEM_WORDS * 2 * (SLOW_GNT_DELAY + 2);
  localparam logic [31:0] MEM_BASE = 32'h0000_1000;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   reg_valid_i;
  logic                   reg_write_i;
  logic [ADDR_WIDTH-1:0]  reg_addr_i;
  logic [DATA_WIDTH-1:0]  reg_wdata_i;
  logic                   reg_ready_o;
  logic [DATA_WIDTH-1:0]  reg_rdata_o;
  logic                   reg_error_o;
  logic                   intr_o;
  logic [EXT_DOMAINS-1:0] powergate_switch_i;
  logic [EXT_DOMAINS-1:0] powergate_switch_ack_o;

  logic [DATA_WIDTH-1:0]  model [MEM_WORDS];
  logic [EXT_DOMAINS-1:0] sw_hist [SWITCH_ACK_LATENCY];
  logic [MEM_IDX_WIDTH-1:0] idx_list [16];
  logic [DATA_WIDTH-1:0]  rdata;
  logic [31:0]            rnd;
  logic                   ack_check_en;
  integer                 seed;
  int                     check_count;
  int                     error_count;
  int                     test_errs;

  ext_subsystem DUT (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .reg_valid_i           (reg_valid_i),
    .reg_write_i           (reg_write_i),
    .reg_addr_i            (reg_addr_i),
    .reg_wdata_i           (reg_wdata_i),
    .reg_ready_o           (reg_ready_o),
    .reg_rdata_o           (reg_rdata_o),
    .reg_error_o           (reg_error_o),
    .intr_o                (intr_o),
    .powergate_switch_i    (powergate_switch_i),
    .powergate_switch_ack_o(powergate_switch_ack_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] window_addr(input logic [MEM_IDX_WIDTH-1:0] idx);
    return MEM_BASE | {23'd0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] csr_addr(input logic [MEM_IDX_WIDTH-1:0] offset);
    return {25'd0, offset};
  endfunction

  // Answer latency in cycles, 0 where the slow memory sets it
  function automatic int ready_latency(input logic [31:0] addr);
    if (addr[31:13] != '0) begin
      return 1;
    end else if (!addr[12]) begin
      return 2;
    end
    return 0;
  endfunction

  // Word-by-word copy with indices wrapping at the memory depth
  function automatic void mem_copy_ref(input logic [31:0] src, input logic [31:0] dst,
                                       input int n_words);
    logic [MEM_IDX_WIDTH-1:0] s_idx;
    logic [MEM_IDX_WIDTH-1:0] d_idx;
    s_idx = src[MEM_IDX_WIDTH+1:2];
    d_idx = dst[MEM_IDX_WIDTH+1:2];
    for (int i = 0; i < n_words; i++) begin
      model[d_idx] = model[s_idx];
      s_idx = s_idx + 1'b1;
      d_idx = d_idx + 1'b1;
    end
  endfunction

  // sw_hist[0] holds the input seen at the previous edge
  function automatic logic [EXT_DOMAINS-1:0] ack_ref(input int latency);
    return sw_hist[latency-1];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic reg_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] data,
                            output logic err);
    int cycles;
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= wr;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    // DUT samples the request at this edge
    @(posedge clk_i);
    cycles = 0;
    while (!reg_ready_o) begin
      @(posedge clk_i);
      cycles++;
    end
    data = reg_rdata_o;
    err  = reg_error_o;
    reg_valid_i <= 1'b0;
    if (ready_latency(addr) != 0) begin
      check_value("reg_ready_o latency", cycles, ready_latency(addr));
    end
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic exp_err);
    logic [31:0] data;
    logic        err;
    reg_access(1'b1, addr, wdata, data, err);
    check_value("reg_error_o", err, exp_err);
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
    logic err;
    reg_access(1'b0, addr, '0, data, err);
    check_value("reg_error_o", err, 1'b0);
  endtask

  task automatic preload(input logic [MEM_IDX_WIDTH-1:0] start_idx, input int n_words);
    logic [MEM_IDX_WIDTH-1:0] idx;
    logic [31:0]              val;
    idx = start_idx;
    for (int k = 0; k < n_words; k++) begin
      val = $random(seed);
      reg_write(window_addr(idx), val, 1'b0);
      model[idx] = val;
      idx = idx + 1'b1;
    end
  endtask

  task automatic verify_range(input logic [MEM_IDX_WIDTH-1:0] start_idx, input int n_words);
    logic [MEM_IDX_WIDTH-1:0] idx;
    logic [31:0]              data;
    idx = start_idx;
    for (int k = 0; k < n_words; k++) begin
      reg_read(window_addr(idx), data);
      check_value("reg_rdata_o", data, model[idx]);
      idx = idx + 1'b1;
    end
  endtask

  task automatic start_copy(input logic [MEM_IDX_WIDTH-1:0] src_idx,
                            input logic [MEM_IDX_WIDTH-1:0] dst_idx, input int n_words);
    preload(src_idx, n_words);
    reg_write(csr_addr(CSR_SRC_OFFSET), {23'd0, src_idx, 2'b00}, 1'b0);
    reg_write(csr_addr(CSR_DST_OFFSET), {23'd0, dst_idx, 2'b00}, 1'b0);
    reg_write(csr_addr(CSR_SIZE_OFFSET), n_words, 1'b0);
  endtask

  task automatic finish_copy(input logic [MEM_IDX_WIDTH-1:0] src_idx,
                             input logic [MEM_IDX_WIDTH-1:0] dst_idx, input int n_words);
    while (!intr_o) @(posedge clk_i);
    mem_copy_ref({23'd0, src_idx, 2'b00}, {23'd0, dst_idx, 2'b00}, n_words);
    verify_range(dst_idx, n_words);
  endtask

  task automatic finish_test(input int num, input string name, input int errs_at_start);
    $display("test %0d %s: %0d checks failed", num, name, error_count - errs_at_start);
  endtask

  // Ack compared with the input history on every enabled cycle
  always @(posedge clk_i) begin
    if (ack_check_en) begin
      check_value("powergate_switch_ack_o", powergate_switch_ack_o,
                  ack_ref(SWITCH_ACK_LATENCY));
    end
    for (int i = SWITCH_ACK_LATENCY - 1; i > 0; i--) begin
      sw_hist[i] = sw_hist[i-1];
    end
    sw_hist[0] = powergate_switch_i;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, DUT stopped responding", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    clk_i              = 1'b0;
    rst_n_i            = 1'b0;
    reg_valid_i        = 1'b0;
    reg_write_i        = 1'b0;
    reg_addr_i         = '0;
    reg_wdata_i        = '0;
    powergate_switch_i = '0;
    ack_check_en       = 1'b0;
    seed               = 32'ha2c8_cdb6;
    check_count        = 0;
    error_count        = 0;
    for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
      sw_hist[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    test_errs = error_count;
    for (int k = 0; k < 16; k++) begin
      rnd = $random(seed);
      idx_list[k] = rnd[MEM_IDX_WIDTH-1:0];
      rnd = $random(seed);
      reg_write(window_addr(idx_list[k]), rnd, 1'b0);
      model[idx_list[k]] = rnd;
    end
    for (int k = 0; k < 16; k++) begin
      reg_read(window_addr(idx_list[k]), rdata);
      check_value("reg_rdata_o", rdata, model[idx_list[k]]);
    end
    finish_test(1, "memory window", test_errs);

    test_errs = error_count;
    reg_read(csr_addr(CSR_STATUS_OFFSET), rdata);
    check_value("status", rdata, 32'h0);
    check_value("intr_o", intr_o, 1'b0);
    reg_write(csr_addr(CSR_SRC_OFFSET), 32'h0000_0124, 1'b0);
    reg_write(csr_addr(CSR_DST_OFFSET), 32'h0000_01f8, 1'b0);
    reg_read(csr_addr(CSR_SRC_OFFSET), rdata);
    check_value("src", rdata, 32'h0000_0124);
    reg_read(csr_addr(CSR_DST_OFFSET), rdata);
    check_value("dst", rdata, 32'h0000_01f8);
    finish_test(2, "csr readback", test_errs);

    test_errs = error_count;
    start_copy(7'd10, 7'd40, 12);
    finish_copy(7'd10, 7'd40, 12);
    reg_read(csr_addr(CSR_STATUS_OFFSET), rdata);
    check_value("status", rdata, 32'h1);
    // Source range runs past index 127
    start_copy(7'd120, 7'd60, 12);
    finish_copy(7'd120, 7'd60, 12);
    finish_test(3, "memcopy", test_errs);

    test_errs = error_count;
    reg_read(csr_addr(CSR_STATUS_OFFSET), rdata);
    check_value("status", rdata, 32'h1);
    check_value("intr_o", intr_o, 1'b0);
    reg_read(csr_addr(CSR_STATUS_OFFSET), rdata);
    check_value("status", rdata, 32'h0);
    finish_test(4, "interrupt clear", test_errs);

    test_errs = error_count;
    reg_write(32'h0000_4000, 32'h0, 1'b1);
    start_copy(7'd70, 7'd90, 12);
    reg_write(csr_addr(CSR_SIZE_OFFSET), 32'd5, 1'b1);
    finish_copy(7'd70, 7'd90, 12);
    reg_read(csr_addr(CSR_STATUS_OFFSET), rdata);
    check_value("status", rdata, 32'h1);
    finish_test(5, "errors", test_errs);

    test_errs = error_count;
    @(posedge clk_i);
    ack_check_en <= 1'b1;
    repeat (60) begin
      @(posedge clk_i);
      rnd = $random(seed);
      powergate_switch_i <= rnd[EXT_DOMAINS-1:0];
    end
    // Let the last patterns reach the ack outputs
    repeat (SWITCH_ACK_LATENCY + 1) @(posedge clk_i);
    ack_check_en <= 1'b0;
    @(posedge clk_i);
    finish_test(6, "power switch", test_errs);

    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
verilog/ext_subsys_pkg.sv
verilog/obi_if.sv
verilog/switch_ack_delay.sv
verilog/slow_memory.sv
verilog/obi_arbiter.sv
verilog/memcopy_ctrl.sv
verilog/periph_decoder.sv
verilog/ext_subsystem.sv
tests/tb_ext_subsystem.sv
